/* exception_unit.f */
+incdir+common
common/exc_pkg.sv
common/exc_pending_if.sv
src/fault_capture.sv
exc_control/exc_sequencer.sv
src/exception_unit.sv
tests/exception_unit_properties.sv
tests/tb_exception_unit.sv

/* Makefile */
# Verilator simulation of the exception unit

VERILATOR ?= verilator
TOP       ?= tb_exception_unit
FLIST     ?= exception_unit.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, fail unless TEST OK is printed"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FLIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)

/* tests/tb_exception_unit.sv */
// --------------------------------------------------
// exception unit testbench with LCG stimulus
// checked against a reference model
// --------------------------------------------------
`timescale 1ns/1ps

module tb_exception_unit;

    // about 40 cycles for each fault, interrupt or reset
    localparam int NUM_TX    = 16 + 16 + 4 + 3 + 6 + 3 * 3 + 2;
    localparam int MAX_CYCLE = 40 * NUM_TX;

    logic        clk;
    logic        rst_n;
    logic [2:0]  dec_faults;
    logic [31:0] dec_eip;
    logic [4:0]  rd_faults;
    logic        rd_pf_fault;
    logic [31:0] rd_eip;
    logic [3:0]  rd_consumed;
    logic [15:0] rd_error_code;
    logic [7:0]  exe_faults;
    logic [31:0] exe_eip;
    logic [3:0]  exe_consumed;
    logic [15:0] exe_error_code;
    logic [2:0]  wr_faults;
    logic [31:0] wr_eip;
    logic [3:0]  wr_consumed;
    logic [15:0] wr_error_code;
    logic        dec_is_front;
    logic        rd_is_front;
    logic        exe_is_front;
    logic        wr_is_front;
    logic [15:0] tlb_pf_error_code;
    logic        int_possible;
    logic [7:0]  int_vector;
    logic        exc_finished;
    logic        int_ack;
    logic        exc_load;
    logic [7:0]  exc_vector;
    logic [15:0] exc_error_code;
    logic [31:0] exc_eip;
    logic        exc_push_error;
    logic        pipe_reset;
    logic        shutdown;

    // --------------------------------------------------
    // reference tables from bit position to vector
    // --------------------------------------------------
    logic [7:0] dec_tab [0:2] = '{8'd13, 8'd6, 8'd14};
    logic [7:0] rd_tab  [0:5] = '{8'd13, 8'd13, 8'd12, 8'd13, 8'd10, 8'd14};
    logic [7:0] exe_tab [0:7] = '{8'd0, 8'd13, 8'd10, 8'd12, 8'd11, 8'd7, 8'd14, 8'd5};
    logic [7:0] wr_tab  [0:2] = '{8'd12, 8'd13, 8'd12};

    // model nesting count, last class and external flag
    int         mdl_cnt;
    int         mdl_last;
    logic       mdl_ext;
    logic [31:0] lcg_state = 32'd23;
    int         errors;
    int         test_errs;
    int         tests_run;
    int         tests_failed;
    int         cycles;

    exception_unit i_exception_unit (.*);

    always #50 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLE) begin
            $display("timeout after %0d cycles, the run did not finish", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    function logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        // upper half has the better randomness
        return {lcg_state[15:0], lcg_state[31:16]};
    endfunction

    function automatic int lowest_bit(input logic [7:0] s);
        int b;
        b = 0;
        for (int i = 7; i >= 0; i--) begin
            if (s[i]) b = i;
        end
        return b;
    endfunction

    // 0 benign, 1 contributory, 2 page fault, 3 double fault
    function automatic int ref_class(input logic [7:0] v);
        if (v == 8'd0 || (v >= 8'd10 && v <= 8'd13)) return 1;
        if (v == 8'd14) return 2;
        if (v == 8'd8) return 3;
        return 0;
    endfunction

    function automatic logic [7:0] nonzero(input logic [7:0] v, input logic [7:0] mask);
        return ((v & mask) == 8'd0) ? 8'd1 : (v & mask);
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic note_fail(input string msg);
        errors++;
        $display("%0t %s", $time, msg);
    endtask

    task automatic begin_test();
        test_errs = errors;
        tests_run++;
    endtask

    task automatic end_test(input string name);
        if (errors != test_errs) begin
            tests_failed++;
            $display("test %0d %s: failed, %0d errors", tests_run, name, errors - test_errs);
        end else begin
            $display("test %0d %s: passed", tests_run, name);
        end
    endtask

    task automatic clear_faults();
        dec_faults   = '0;
        rd_faults    = '0;
        rd_pf_fault  = 1'b0;
        exe_faults   = '0;
        wr_faults    = '0;
        dec_is_front = 1'b0;
        rd_is_front  = 1'b0;
        exe_is_front = 1'b0;
        wr_is_front  = 1'b0;
    endtask

    task automatic apply_reset();
        rst_n        = 1'b0;
        clear_faults();
        int_possible = 1'b0;
        int_vector   = '0;
        exc_finished = 1'b0;
        repeat (5) @(negedge clk);
        rst_n    = 1'b1;
        mdl_cnt  = 0;
        mdl_last = 0;
        mdl_ext  = 1'b0;
    endtask

    task automatic pulse_finished();
        exc_finished = 1'b1;
        @(negedge clk);
        exc_finished = 1'b0;
        mdl_cnt  = 0;
        mdl_last = 0;
        mdl_ext  = 1'b0;
    endtask

    // addresses, lengths and error codes
    task automatic random_payload();
        dec_eip           = lcg_next();
        rd_eip            = lcg_next();
        exe_eip           = lcg_next();
        wr_eip            = lcg_next();
        rd_consumed       = 4'(lcg_next());
        exe_consumed      = 4'(lcg_next());
        wr_consumed       = 4'(lcg_next());
        rd_error_code     = 16'(lcg_next());
        exe_error_code    = 16'(lcg_next());
        wr_error_code     = 16'(lcg_next());
        tlb_pf_error_code = 16'(lcg_next());
    endtask

    // front stage by wr > exe > rd > dec and then lowest bit
    task automatic predict_fault(output logic [7:0] v, output logic [15:0] e,
                                 output logic [31:0] ip);
        v  = '0;
        e  = '0;
        ip = '0;
        if (wr_is_front && wr_faults != 0) begin
            v  = wr_tab[lowest_bit({5'd0, wr_faults})];
            e  = wr_error_code;
            ip = wr_eip - {28'd0, wr_consumed};
        end else if (exe_is_front && exe_faults != 0) begin
            v  = exe_tab[lowest_bit(exe_faults)];
            e  = (v == 8'd14) ? tlb_pf_error_code : exe_error_code;
            ip = exe_eip - {28'd0, exe_consumed};
        end else if (rd_is_front && {rd_pf_fault, rd_faults} != 0) begin
            v  = rd_tab[lowest_bit({2'd0, rd_pf_fault, rd_faults})];
            e  = (v == 8'd14) ? tlb_pf_error_code : rd_error_code;
            ip = rd_eip - {28'd0, rd_consumed};
        end else begin
            v  = dec_tab[lowest_bit({5'd0, dec_faults})];
            e  = (v == 8'd14) ? tlb_pf_error_code : 16'd0;
            ip = dec_eip;
        end
    endtask

    // --------------------------------------------------
    // one fault through the unit with the model deciding
    // --------------------------------------------------
    task automatic fault_case(input logic [2:0] d, input logic [5:0] r,
                              input logic [7:0] x, input logic [2:0] w,
                              input logic [3:0] fr);
        logic [7:0]  v;
        logic [15:0] e;
        logic [31:0] ip;
        int          cls;
        int          lat_exp;
        int          lat;
        logic        shut_exp;
        logic [15:0] e_exp;
        logic        push_exp;
        dec_faults  = d;
        rd_faults   = r[4:0];
        rd_pf_fault = r[5];
        exe_faults  = x;
        wr_faults   = w;
        {wr_is_front, exe_is_front, rd_is_front, dec_is_front} = fr;
        predict_fault(v, e, ip);
        cls      = ref_class(v);
        lat_exp  = 2;
        shut_exp = 1'b0;
        if (mdl_cnt > 2 || (mdl_cnt != 0 && mdl_last == 3)) begin
            shut_exp = 1'b1;
        end else if (mdl_cnt != 0 && ((cls == 1 && (mdl_last == 1 || mdl_last == 2)) ||
                                      (cls == 2 && mdl_last == 2))) begin
            // promoted to a double fault one cycle later
            v       = 8'd8;
            e       = 16'd0;
            cls     = 3;
            lat_exp = 3;
        end
        e_exp    = (v == 8'd14 || v == 8'd8) ? e : {e[15:1], mdl_ext};
        push_exp = (v == 8'd8) || (v >= 8'd10 && v <= 8'd14);
        for (lat = 1; lat <= 6; lat++) begin
            @(negedge clk);
            if (lat == 1) clear_faults();
            if (exc_load) break;
            if (!pipe_reset) note_fail("pipe_reset low while a fault is pending");
        end
        if (shut_exp) begin
            if (lat <= 6) note_fail("exc_load after a fault that should shut down");
            check_val("shutdown", shutdown, 1);
        end else if (lat > 6) begin
            note_fail("no exc_load after a fault");
        end else begin
            check_val("latency", lat, lat_exp);
            check_val("exc_vector", exc_vector, v);
            check_val("exc_error_code", exc_error_code, e_exp);
            check_val("exc_eip", exc_eip, ip);
            check_val("exc_push_error", exc_push_error, push_exp);
            mdl_cnt++;
            mdl_last = cls;
            mdl_ext  = 1'b1;
        end
    endtask

    task automatic interrupt_case();
        logic [7:0] vec;
        vec          = 8'(lcg_next());
        int_vector   = vec;
        wr_eip       = lcg_next();
        int_possible = 1'b1;
        @(negedge clk);
        int_possible = 1'b0;
        check_val("int_ack", int_ack, 1);
        check_val("pipe_reset", pipe_reset, 1);
        @(negedge clk);
        check_val("int_ack", int_ack, 0);
        check_val("exc_load", exc_load, 1);
        check_val("exc_vector", exc_vector, vec);
        check_val("exc_error_code", exc_error_code, 0);
        check_val("exc_push_error", exc_push_error, 0);
        check_val("exc_eip", exc_eip, wr_eip);
        mdl_ext = 1'b1;
        @(negedge clk);
    endtask

    // --------------------------------------------------
    // test sequence
    // --------------------------------------------------
    initial begin
        logic [2:0] d;
        logic [5:0] r;
        logic [7:0] x;
        logic [2:0] w;
        logic [3:0] fr;
        int         stage;
        clk          = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        cycles       = 0;
        random_payload();
        apply_reset();

        // single faults in one stage at a time
        begin_test();
        for (int i = 0; i < 16; i++) begin
            pulse_finished();
            random_payload();
            stage = int'(lcg_next() % 4);
            d = (stage == 0) ? 3'(nonzero(8'(lcg_next()), 8'h07)) : 3'd0;
            r = (stage == 1) ? 6'(nonzero(8'(lcg_next()), 8'h3f)) : 6'd0;
            x = (stage == 2) ? nonzero(8'(lcg_next()), 8'hff) : 8'd0;
            w = (stage == 3) ? 3'(nonzero(8'(lcg_next()), 8'h07)) : 3'd0;
            fault_case(d, r, x, w, 4'b1 << stage);
        end
        end_test("single faults");

        // several stages with random front flags
        begin_test();
        for (int i = 0; i < 16; i++) begin
            pulse_finished();
            random_payload();
            do begin
                d  = 3'(lcg_next());
                r  = 6'(lcg_next());
                x  = 8'(lcg_next());
                w  = 3'(lcg_next());
                fr = 4'(lcg_next());
            end while (!((fr[0] && d != 0) || (fr[1] && r != 0) ||
                         (fr[2] && x != 0) || (fr[3] && w != 0)));
            fault_case(d, r, x, w, fr);
        end
        end_test("stage priority");

        // contributory pairs promote to vector 8
        begin_test();
        pulse_finished();
        random_payload();
        fault_case(3'd0, 6'd0, 8'h02, 3'd0, 4'b0100);
        fault_case(3'd0, 6'd0, 8'h04, 3'd0, 4'b0100);
        pulse_finished();
        fault_case(3'd0, 6'd0, 8'h40, 3'd0, 4'b0100);
        fault_case(3'd0, 6'h01, 8'd0, 3'd0, 4'b0010);
        end_test("double fault");

        // fault on top of a double fault
        begin_test();
        pulse_finished();
        fault_case(3'd0, 6'd0, 8'h02, 3'd0, 4'b0100);
        fault_case(3'd0, 6'd0, 8'h08, 3'd0, 4'b0100);
        fault_case(3'd0, 6'd0, 8'd0, 3'h1, 4'b1000);
        repeat (3) begin
            @(negedge clk);
            check_val("shutdown", shutdown, 1);
            check_val("pipe_reset", pipe_reset, 1);
            check_val("exc_load", exc_load, 0);
        end
        apply_reset();
        check_val("shutdown", shutdown, 0);
        check_val("pipe_reset", pipe_reset, 0);
        end_test("shutdown");

        begin_test();
        for (int i = 0; i < 6; i++) begin
            pulse_finished();
            interrupt_case();
        end
        end_test("interrupts");

        // external flag forces error bit 0
        begin_test();
        for (int i = 0; i < 3; i++) begin
            pulse_finished();
            random_payload();
            exe_error_code[0] = 1'b0;
            fault_case(3'd0, 6'd0, 8'h20, 3'd0, 4'b0100);
            fault_case(3'd0, 6'd0, 8'h02, 3'd0, 4'b0100);
            check_val("exc_error_code[0]", exc_error_code[0], 1);
            pulse_finished();
            fault_case(3'd0, 6'd0, 8'h02, 3'd0, 4'b0100);
            check_val("exc_error_code[0]", exc_error_code[0], 0);
        end
        end_test("external flag");

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* tests/exception_unit_properties.sv */
// --------------------------------------------------
// bound assertions on the exception unit outputs
// --------------------------------------------------
`timescale 1ns/1ps

module exception_unit_properties (
    input logic clk,
    input logic rst_n,
    input logic exc_load,
    input logic pipe_reset,
    input logic shutdown
);

    // one delivery pulse at a time
    load_single_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) exc_load |=> !exc_load
    ) else $error("exc_load high for two cycles");

    // sticky until reset
    shutdown_sticky: assert property (
        @(posedge clk) $fell(shutdown) |-> (!rst_n || $past(!rst_n))
    ) else $error("shutdown fell without reset");

    // every delivery follows a cycle with the pipeline held in reset
    load_after_pipe_reset: assert property (
        @(posedge clk) disable iff (!rst_n) exc_load |-> $past(pipe_reset)
    ) else $error("exc_load without pipe_reset in the cycle before");

endmodule

bind exception_unit exception_unit_properties i_exception_unit_properties (
    .clk        (clk),
    .rst_n      (rst_n),
    .exc_load   (exc_load),
    .pipe_reset (pipe_reset),
    .shutdown   (shutdown)
);

/* src/exception_unit.sv */
// --------------------------------------------------
// exception unit top level, plain ports to the core
// pipeline, capture feeds the sequencer
// --------------------------------------------------
`timescale 1ns/1ps
`include "exc_macros.svh"

module exception_unit import exc_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    // stage faults and addresses
    input  dec_faults_t            dec_faults,
    input  addr_t                  dec_eip,
    input  logic [`RD_PF_BIT-1:0]  rd_faults,
    input  logic                   rd_pf_fault,
    input  addr_t                  rd_eip,
    input  len_t                   rd_consumed,
    input  err_t                   rd_error_code,
    input  exe_faults_t            exe_faults,
    input  addr_t                  exe_eip,
    input  len_t                   exe_consumed,
    input  err_t                   exe_error_code,
    input  wr_faults_t             wr_faults,
    input  addr_t                  wr_eip,
    input  len_t                   wr_consumed,
    input  err_t                   wr_error_code,
    input  logic                   dec_is_front,
    input  logic                   rd_is_front,
    input  logic                   exe_is_front,
    input  logic                   wr_is_front,
    input  err_t                   tlb_pf_error_code,
    // interrupts and completion
    input  logic                   int_possible,
    input  vec_t                   int_vector,
    input  logic                   exc_finished,
    output logic                   int_ack,
    // delivery to the core
    output logic                   exc_load,
    output vec_t                   exc_vector,
    output err_t                   exc_error_code,
    output addr_t                  exc_eip,
    output logic                   exc_push_error,
    output logic                   pipe_reset,
    output logic                   shutdown
);

    exc_pending_if pend ();

    fault_capture i_fault_capture (
        .clk               (clk),
        .rst_n             (rst_n),
        .dec_faults        (dec_faults),
        .dec_eip           (dec_eip),
        // rd page fault becomes the lowest priority rd bit
        .rd_faults         ({rd_pf_fault, rd_faults}),
        .rd_eip            (rd_eip),
        .rd_consumed       (rd_consumed),
        .rd_error_code     (rd_error_code),
        .exe_faults        (exe_faults),
        .exe_eip           (exe_eip),
        .exe_consumed      (exe_consumed),
        .exe_error_code    (exe_error_code),
        .wr_faults         (wr_faults),
        .wr_eip            (wr_eip),
        .wr_consumed       (wr_consumed),
        .wr_error_code     (wr_error_code),
        .dec_is_front      (dec_is_front),
        .rd_is_front       (rd_is_front),
        .exe_is_front      (exe_is_front),
        .wr_is_front       (wr_is_front),
        .tlb_pf_error_code (tlb_pf_error_code),
        .pend              (pend.capture)
    );

    exc_sequencer i_exc_sequencer (
        .clk            (clk),
        .rst_n          (rst_n),
        .pend           (pend.seq),
        .int_possible   (int_possible),
        .int_vector     (int_vector),
        .exc_finished   (exc_finished),
        .int_ack        (int_ack),
        .exc_load       (exc_load),
        .exc_vector     (exc_vector),
        .exc_error_code (exc_error_code),
        .exc_eip        (exc_eip),
        .exc_push_error (exc_push_error),
        .pipe_reset     (pipe_reset),
        .shutdown       (shutdown)
    );

endmodule

/* exc_control/exc_sequencer.sv */
// --------------------------------------------------
// classifies the pending fault, promotes or shuts
// down, accepts interrupts, drives the exc_* outputs
// --------------------------------------------------
`timescale 1ns/1ps
`include "exc_macros.svh"

module exc_sequencer import exc_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    exc_pending_if.seq pend,
    input  logic       int_possible,
    input  vec_t       int_vector,
    input  logic       exc_finished,
    output logic       int_ack,
    output logic       exc_load,
    output vec_t       exc_vector,
    output err_t       exc_error_code,
    output addr_t      exc_eip,
    output logic       exc_push_error,
    output logic       pipe_reset,
    output logic       shutdown
);

    // --------------------------------------------------
    // classification
    // --------------------------------------------------
    function automatic exc_class_t classify(vec_t v);
        if (v == `EXC_DE || (v >= `EXC_TS && v <= `EXC_GP)) return cls_contributory;
        if (v == `EXC_PF) return cls_page_fault;
        if (v == `EXC_DF) return cls_double_fault;
        return cls_benign;
    endfunction

    // vectors that push an error code
    function automatic logic pushes_error(vec_t v);
        return v == `EXC_DF || v == `EXC_TS || v == `EXC_NP ||
               v == `EXC_SS || v == `EXC_GP || v == `EXC_PF;
    endfunction

    seq_state_t state;
    logic [1:0] count;
    exc_class_t last_class;
    logic       external;
    exc_class_t pend_class;
    logic       nested;
    logic       shutdown_start;
    logic       promote;
    logic       take;
    logic       accept;
    err_t       acc_err;

    assign pend_class = classify(pend.vector);
    assign nested     = (count != 2'd0);

    // too deep, or a fault on top of a double fault
    assign shutdown_start = (count > 2'(`EXC_COUNT_LIMIT)) ||
                            (nested && last_class == cls_double_fault);

    // benign never pairs into a double fault
    assign promote = !shutdown_start && nested &&
                     ((pend_class == cls_contributory &&
                       (last_class == cls_contributory || last_class == cls_page_fault)) ||
                      (pend_class == cls_page_fault && last_class == cls_page_fault));

    assign take   = pend.valid && (state == seq_idle);
    assign accept = take && !promote && !shutdown_start;

    // decision back to capture in the same cycle
    assign pend.rewrite = take && promote;
    assign pend.clear   = take && !promote;
    assign pend.hold    = int_possible || int_ack || (state == seq_shutdown);

    // bit 0 tells the handler the event was nested
    assign acc_err = (pend.vector == `EXC_PF || pend.vector == `EXC_DF) ?
                     pend.error_code : {pend.error_code[15:1], external};

    // --------------------------------------------------
    // control state
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= seq_idle;
        end else if (take && shutdown_start) begin
            // leaves only through reset
            state <= seq_shutdown;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            int_ack  <= 1'b0;
            exc_load <= 1'b0;
        end else begin
            int_ack  <= int_possible && !pend.valid && (state == seq_idle);
            exc_load <= accept || int_ack;
        end
    end

    // nesting bookkeeping, exc_finished ends the chain
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count      <= 2'd0;
            last_class <= cls_benign;
            external   <= 1'b0;
        end else if (exc_finished) begin
            count      <= 2'd0;
            last_class <= cls_benign;
            external   <= 1'b0;
        end else begin
            if (accept) begin
                count      <= count + 2'd1;
                last_class <= pend_class;
            end
            if (accept || int_ack) begin
                external <= 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // output payload
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (accept) begin
            exc_vector     <= pend.vector;
            exc_error_code <= acc_err;
            exc_eip        <= pend.eip;
            exc_push_error <= pushes_error(pend.vector);
        end else if (int_ack) begin
            // external interrupt, returns to wr_eip
            exc_vector     <= int_vector;
            exc_error_code <= '0;
            exc_eip        <= pend.eip;
            exc_push_error <= 1'b0;
        end
    end

    assign shutdown   = (state == seq_shutdown);
    assign pipe_reset = pend.valid || int_ack || shutdown;

endmodule

/* src/fault_capture.sv */
// --------------------------------------------------
// picks the front faulting stage and registers its
// vector, error code and restart address
// --------------------------------------------------
`timescale 1ns/1ps
`include "exc_macros.svh"

module fault_capture import exc_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  dec_faults_t  dec_faults,
    input  addr_t        dec_eip,
    input  rd_faults_t   rd_faults,
    input  addr_t        rd_eip,
    input  len_t         rd_consumed,
    input  err_t         rd_error_code,
    input  exe_faults_t  exe_faults,
    input  addr_t        exe_eip,
    input  len_t         exe_consumed,
    input  err_t         exe_error_code,
    input  wr_faults_t   wr_faults,
    input  addr_t        wr_eip,
    input  len_t         wr_consumed,
    input  err_t         wr_error_code,
    input  logic         dec_is_front,
    input  logic         rd_is_front,
    input  logic         exe_is_front,
    input  logic         wr_is_front,
    input  err_t         tlb_pf_error_code,
    exc_pending_if.capture pend
);

    // --------------------------------------------------
    // bit to vector tables, lowest bit first
    // --------------------------------------------------
    function automatic vec_t dec_vector(dec_faults_t f);
        if (f[`DEC_GP_BIT]) return `EXC_GP;
        if (f[`DEC_UD_BIT]) return `EXC_UD;
        if (f[`DEC_PF_BIT]) return `EXC_PF;
        return '0;
    endfunction

    function automatic vec_t rd_vector(rd_faults_t f);
        if (f[`RD_SEG_GP_BIT]) return `EXC_GP;
        if (f[`RD_DESC_GP_BIT]) return `EXC_GP;
        if (f[`RD_SEG_SS_BIT]) return `EXC_SS;
        if (f[`RD_IO_GP_BIT]) return `EXC_GP;
        if (f[`RD_TSS_TS_BIT]) return `EXC_TS;
        if (f[`RD_PF_BIT]) return `EXC_PF;
        return '0;
    endfunction

    function automatic vec_t exe_vector(exe_faults_t f);
        if (f[`EXE_DE_BIT]) return `EXC_DE;
        if (f[`EXE_GP_BIT]) return `EXC_GP;
        if (f[`EXE_TS_BIT]) return `EXC_TS;
        if (f[`EXE_SS_BIT]) return `EXC_SS;
        if (f[`EXE_NP_BIT]) return `EXC_NP;
        if (f[`EXE_NM_BIT]) return `EXC_NM;
        if (f[`EXE_PF_BIT]) return `EXC_PF;
        if (f[`EXE_BR_BIT]) return `EXC_BR;
        return '0;
    endfunction

    function automatic vec_t wr_vector(wr_faults_t f);
        if (f[`WR_NEW_SS_BIT]) return `EXC_SS;
        if (f[`WR_STR_GP_BIT]) return `EXC_GP;
        if (f[`WR_PUSH_SS_BIT]) return `EXC_SS;
        return '0;
    endfunction

    // restart at the first byte of the instruction
    function automatic addr_t restart_eip(addr_t eip, len_t len);
        return eip - addr_t'(len);
    endfunction

    // --------------------------------------------------
    // stage arbitration
    // --------------------------------------------------
    logic  open_q;
    logic  act_dec;
    logic  act_rd;
    logic  act_exe;
    logic  act_wr;
    logic  any_act;
    vec_t  sel_vec;
    err_t  sel_err;
    addr_t sel_eip;
    logic  valid_q;
    vec_t  vec_q;
    err_t  err_q;
    addr_t eip_q;

    // nothing new while a fault waits or the sequencer holds
    assign open_q  = !valid_q && !pend.hold;
    assign act_dec = open_q && dec_is_front && (|dec_faults);
    assign act_rd  = open_q && rd_is_front && (|rd_faults);
    assign act_exe = open_q && exe_is_front && (|exe_faults);
    assign act_wr  = open_q && wr_is_front && (|wr_faults);
    assign any_act = act_dec || act_rd || act_exe || act_wr;

    // wr > exe > rd > dec
    always_comb begin
        sel_vec = '0;
        sel_err = '0;
        sel_eip = '0;
        if (act_wr) begin
            sel_vec = wr_vector(wr_faults);
            sel_err = wr_error_code;
            sel_eip = restart_eip(wr_eip, wr_consumed);
        end else if (act_exe) begin
            sel_vec = exe_vector(exe_faults);
            sel_err = (sel_vec == `EXC_PF) ? tlb_pf_error_code : exe_error_code;
            sel_eip = restart_eip(exe_eip, exe_consumed);
        end else if (act_rd) begin
            sel_vec = rd_vector(rd_faults);
            sel_err = (sel_vec == `EXC_PF) ? tlb_pf_error_code : rd_error_code;
            sel_eip = restart_eip(rd_eip, rd_consumed);
        end else if (act_dec) begin
            sel_vec = dec_vector(dec_faults);
            // other decode faults push zero
            sel_err = (sel_vec == `EXC_PF) ? tlb_pf_error_code : '0;
            sel_eip = dec_eip;
        end
    end

    // --------------------------------------------------
    // pending fault register
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (pend.rewrite) begin
            valid_q <= 1'b1;
        end else if (pend.clear) begin
            valid_q <= 1'b0;
        end else if (any_act) begin
            valid_q <= 1'b1;
        end
    end

    // payload, eip kept across a double fault rewrite
    always_ff @(posedge clk) begin
        if (pend.rewrite) begin
            vec_q <= `EXC_DF;
            err_q <= '0;
        end else if (any_act) begin
            vec_q <= sel_vec;
            err_q <= sel_err;
            eip_q <= sel_eip;
        end
    end

    assign pend.valid      = valid_q;
    assign pend.vector     = vec_q;
    assign pend.error_code = err_q;
    // idle: wr_eip passes through as the interrupt return address
    assign pend.eip        = valid_q ? eip_q : wr_eip;

endmodule

/* common/exc_pending_if.sv */
// --------------------------------------------------
// pending fault from capture to sequencer, with the
// hold, rewrite and clear controls going back
// --------------------------------------------------
`timescale 1ns/1ps

interface exc_pending_if import exc_pkg::*; ();

    // captured fault
    logic  valid;
    vec_t  vector;
    err_t  error_code;
    addr_t eip;

    // sequencer controls
    logic  hold;
    logic  rewrite;
    logic  clear;

    modport capture (
        output valid, vector, error_code, eip,
        input  hold, rewrite, clear
    );

    modport seq (
        input  valid, vector, error_code, eip,
        output hold, rewrite, clear
    );

endinterface

/* common/exc_pkg.sv */
// --------------------------------------------------
// shared types of the exception unit, imported by
// the interface and every RTL module
// --------------------------------------------------
`include "exc_macros.svh"

package exc_pkg;

    // vector number, exception or interrupt
    typedef logic [7:0] vec_t;

    // restart address
    typedef logic [31:0] addr_t;

    // bytes consumed by the faulting instruction
    typedef logic [3:0] len_t;

    // pushed error code
    typedef logic [15:0] err_t;

    // --------------------------------------------------
    // per-stage fault sets
    // --------------------------------------------------
    typedef logic [`DEC_PF_BIT:0] dec_faults_t;
    // includes the appended rd page fault bit
    typedef logic [`RD_PF_BIT:0] rd_faults_t;
    typedef logic [`EXE_BR_BIT:0] exe_faults_t;
    typedef logic [`WR_PUSH_SS_BIT:0] wr_faults_t;

    // class used for double fault promotion
    typedef enum logic [1:0] {
        cls_benign       = 2'd0,
        cls_contributory = 2'd1,
        cls_page_fault   = 2'd2,
        cls_double_fault = 2'd3
    } exc_class_t;

    // sequencer state, shutdown is sticky
    typedef enum logic {
        seq_idle     = 1'b0,
        seq_shutdown = 1'b1
    } seq_state_t;

endpackage

/* common/exc_macros.svh */
// --------------------------------------------------
// exception vector numbers and fault bit positions,
// include wherever vectors or fault sets are decoded
// --------------------------------------------------
`ifndef EXC_MACROS_SVH
`define EXC_MACROS_SVH

// --------------------------------------------------
// x86 vector numbers
// --------------------------------------------------
`define EXC_DE 8'd0
`define EXC_BR 8'd5
`define EXC_UD 8'd6
`define EXC_NM 8'd7
`define EXC_DF 8'd8
`define EXC_TS 8'd10
`define EXC_NP 8'd11
`define EXC_SS 8'd12
`define EXC_GP 8'd13
`define EXC_PF 8'd14

// nested exceptions allowed before shutdown
`define EXC_COUNT_LIMIT 2

// --------------------------------------------------
// fault bit positions, bit 0 wins within a stage
// --------------------------------------------------
// decode
`define DEC_GP_BIT 0
`define DEC_UD_BIT 1
`define DEC_PF_BIT 2

// read, pf bit appended at top level
`define RD_SEG_GP_BIT 0
`define RD_DESC_GP_BIT 1
`define RD_SEG_SS_BIT 2
`define RD_IO_GP_BIT 3
`define RD_TSS_TS_BIT 4
`define RD_PF_BIT 5

// execute
`define EXE_DE_BIT 0
`define EXE_GP_BIT 1
`define EXE_TS_BIT 2
`define EXE_SS_BIT 3
`define EXE_NP_BIT 4
`define EXE_NM_BIT 5
`define EXE_PF_BIT 6
`define EXE_BR_BIT 7

// write
`define WR_NEW_SS_BIT 0
`define WR_STR_GP_BIT 1
`define WR_PUSH_SS_BIT 2

`endif
